/* rtl/mem_cfg_pkg.sv */
// Fixed memory geometry of four clients, 256 words of 16 bits and bursts of 8; every size comes from here
package mem_cfg_pkg;

	// Address and data widths
	localparam int AN = 8;
	localparam int DN = 16;

	// Client count and read burst length are set by the console system
	localparam int IN = 4;
	localparam int BURST = 8;

	// Words in the on-chip array
	localparam int DEPTH = 1 << AN;

	// One memory word address, wraps at the top of the array
	typedef logic [AN - 1:0] addr_t;

	// One data word
	typedef logic [DN - 1:0] word_t;

	// Client index, also the owner tag on returned data
	typedef logic [$clog2(IN) - 1:0] client_t;

endpackage

/* rtl/mem_cmd_pkg.sv */
// Command encodings for the shared memory path; the beat counter is sized for a power-of-two burst length
package mem_cmd_pkg;

	// Memory operation carried with each request
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

	// Arbiter FSM
	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_ISSUE = 2'd1,
		ARB_WAIT  = 2'd2
	} arb_state_e;

	// Counts the words of one read burst
	typedef logic [$clog2(mem_cfg_pkg::BURST) - 1:0] beat_t;

endpackage

/* rtl/client_port.sv */
// One client slot; the client must hold req, addr, data and wr until ack, and a new request waits for the port's read burst to finish
`timescale 1ns/1ps

module client_port #(
	parameter mem_cfg_pkg::client_t ID = '0
) (
	input  logic                  clk10M,
	input  logic                  arst_n,
	// Client request
	input  logic                  req,
	input  mem_cfg_pkg::addr_t    addr,
	input  mem_cfg_pkg::word_t    data,
	input  logic                  wr,
	// Arbiter grant and shared read return
	input  logic                  grant,
	input  logic                  rsp_valid,
	input  mem_cfg_pkg::client_t  rsp_owner,
	// Back to the client
	output logic                  ack,
	output logic                  valid,
	// Pending request seen by the arbiter
	output logic                  pend,
	output mem_cmd_pkg::mem_op_e  pend_op,
	output mem_cfg_pkg::addr_t    pend_addr,
	output mem_cfg_pkg::word_t    pend_data
);

	logic take;
	logic rd_out;
	mem_cmd_pkg::beat_t rd_cnt;

	// New request accepted only with the slot empty and no burst in flight
	assign take = req && !pend && !rd_out;

	// Ack in the same cycle as the grant
	assign ack = grant && pend;

	// Pick own words off the shared return bus
	assign valid = rsp_valid && (rsp_owner == ID);

	always_ff @(posedge clk10M or negedge arst_n) begin
		if (!arst_n) begin
			pend <= 1'b0;
		end else if (take) begin
			pend <= 1'b1;
		end else if (ack) begin
			pend <= 1'b0;
		end
	end

	always_ff @(posedge clk10M) begin
		if (take) begin
			pend_op <= wr ? mem_cmd_pkg::OP_WRITE : mem_cmd_pkg::OP_READ;
			pend_addr <= addr;
			pend_data <= data;
		end
	end

	// Outstanding read, cleared after the last word of the burst
	always_ff @(posedge clk10M or negedge arst_n) begin
		if (!arst_n) begin
			rd_out <= 1'b0;
			rd_cnt <= '0;
		end else if (ack && pend_op == mem_cmd_pkg::OP_READ) begin
			rd_out <= 1'b1;
			rd_cnt <= '0;
		end else if (valid) begin
			if (rd_cnt == mem_cmd_pkg::beat_t'(mem_cfg_pkg::BURST - 1)) begin
				rd_out <= 1'b0;
				rd_cnt <= '0;
			end else begin
				rd_cnt <= rd_cnt + 1'b1;
			end
		end
	end

	// Client holds its request until acked
	assert property (@(posedge clk10M) disable iff (!arst_n)
		req && !ack |=> req && $stable(addr) && $stable(wr));

	// Arbiter only grants a pending port, so ack never comes without one
	assert property (@(posedge clk10M) disable iff (!arst_n)
		grant |-> pend);

	// Own words arrive only while a read is outstanding
	assert property (@(posedge clk10M) disable iff (!arst_n)
		valid |-> rd_out);

endmodule

/* rtl/rr_arbiter.sv */
// Round-robin arbiter for a fixed client count; one command in flight, completing in grant order
`timescale 1ns/1ps

module rr_arbiter (
	input  logic                         clk10M,
	input  logic                         arst_n,
	// Pending requests from the ports
	input  logic [mem_cfg_pkg::IN - 1:0] pend,
	input  mem_cmd_pkg::mem_op_e         pend_op [mem_cfg_pkg::IN],
	input  mem_cfg_pkg::addr_t           pend_addr [mem_cfg_pkg::IN],
	input  mem_cfg_pkg::word_t           pend_data [mem_cfg_pkg::IN],
	// Memory status
	input  logic                         busy,
	// One-hot grant back to the ports
	output logic [mem_cfg_pkg::IN - 1:0] grant,
	// Command to the memory
	output logic                         cmd_valid,
	output mem_cmd_pkg::mem_op_e         cmd_op,
	output mem_cfg_pkg::addr_t           cmd_addr,
	output mem_cfg_pkg::word_t           cmd_data,
	output mem_cfg_pkg::client_t         cmd_owner
);

	mem_cmd_pkg::arb_state_e state;
	mem_cfg_pkg::client_t last;
	mem_cfg_pkg::client_t sel;
	logic [mem_cfg_pkg::IN - 1:0] one_hot;
	logic found;
	logic start;

	// Search from the client after the last grant
	always_comb begin
		mem_cfg_pkg::client_t idx;
		found = 1'b0;
		sel = last;
		for (int k = 1; k <= mem_cfg_pkg::IN; k++) begin
			idx = last + mem_cfg_pkg::client_t'(k);
			if (!found && pend[idx]) begin
				found = 1'b1;
				sel = idx;
			end
		end
		one_hot = '0;
		one_hot[sel] = 1'b1;
	end

	assign start = (state == mem_cmd_pkg::ARB_IDLE) && !busy && found;

	always_ff @(posedge clk10M or negedge arst_n) begin
		if (!arst_n) begin
			state <= mem_cmd_pkg::ARB_IDLE;
			grant <= '0;
			cmd_valid <= 1'b0;
			// Pointer so that client 0 is searched first
			last <= mem_cfg_pkg::client_t'(mem_cfg_pkg::IN - 1);
		end else begin
			case (state)
				mem_cmd_pkg::ARB_IDLE: begin
					if (start) begin
						grant <= one_hot;
						last <= sel;
						state <= mem_cmd_pkg::ARB_ISSUE;
					end
				end
				mem_cmd_pkg::ARB_ISSUE: begin
					grant <= '0;
					cmd_valid <= 1'b1;
					state <= mem_cmd_pkg::ARB_WAIT;
				end
				mem_cmd_pkg::ARB_WAIT: begin
					cmd_valid <= 1'b0;
					// busy only rises the cycle after cmd_valid
					if (!cmd_valid && !busy)
						state <= mem_cmd_pkg::ARB_IDLE;
				end
				default: begin
					grant <= '0;
					cmd_valid <= 1'b0;
					state <= mem_cmd_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	// Command payload of the granted port
	always_ff @(posedge clk10M) begin
		if (start) begin
			cmd_op <= pend_op[sel];
			cmd_addr <= pend_addr[sel];
			cmd_data <= pend_data[sel];
			cmd_owner <= sel;
		end
	end

	assert property (@(posedge clk10M) disable iff (!arst_n)
		$onehot0(grant));

endmodule

/* rtl/burst_ram.sv */
// On-chip stand-in for the SDRAM with no refresh or command timing; reads return BURST words and wrap at the top address
`timescale 1ns/1ps

module burst_ram (
	input  logic                  clk10M,
	input  logic                  arst_n,
	// Command from the arbiter
	input  logic                  cmd_valid,
	input  mem_cmd_pkg::mem_op_e  cmd_op,
	input  mem_cfg_pkg::addr_t    cmd_addr,
	input  mem_cfg_pkg::word_t    cmd_data,
	input  mem_cfg_pkg::client_t  cmd_owner,
	// High while a burst is streaming
	output logic                  busy,
	// Shared read return
	output logic                  rsp_valid,
	output mem_cfg_pkg::client_t  rsp_owner,
	output mem_cfg_pkg::word_t    rsp_data
);

	mem_cfg_pkg::word_t mem [mem_cfg_pkg::DEPTH];

	logic streaming;
	logic rd_start;
	logic wr_en;
	logic last_beat;
	mem_cmd_pkg::beat_t beat;
	mem_cfg_pkg::addr_t rd_addr;

	assign rd_start = cmd_valid && (cmd_op == mem_cmd_pkg::OP_READ);
	assign wr_en = cmd_valid && (cmd_op == mem_cmd_pkg::OP_WRITE);
	assign last_beat = streaming && (beat == mem_cmd_pkg::beat_t'(mem_cfg_pkg::BURST - 1));

	// Burst sequencing
	always_ff @(posedge clk10M or negedge arst_n) begin
		if (!arst_n) begin
			streaming <= 1'b0;
			beat <= '0;
		end else if (rd_start) begin
			streaming <= 1'b1;
			beat <= '0;
		end else if (last_beat) begin
			streaming <= 1'b0;
		end else if (streaming) begin
			beat <= beat + 1'b1;
		end
	end

	// Array access, one word per cycle
	always_ff @(posedge clk10M) begin
		if (wr_en)
			mem[cmd_addr] <= cmd_data;
		if (rd_start) begin
			rsp_data <= mem[cmd_addr];
			rsp_owner <= cmd_owner;
			rd_addr <= cmd_addr + 1'b1;
		end else if (streaming) begin
			// 8-bit address rolls over to 0 on its own
			rsp_data <= mem[rd_addr];
			rd_addr <= rd_addr + 1'b1;
		end
	end

	assign busy = streaming;
	assign rsp_valid = streaming;

	assert property (@(posedge clk10M) disable iff (!arst_n)
		cmd_valid |-> !busy);

	// Owner tag holds for the whole burst
	assert property (@(posedge clk10M) disable iff (!arst_n)
		streaming && !last_beat |=> $stable(rsp_owner));

endmodule

/* rtl/mem_shared.sv */
// Shared memory path top; client i uses arb_*[i] with a req/ack handshake and watches arb_valid[i] on the shared data bus
`timescale 1ns/1ps

module mem_shared (
	input  logic                         clk10M,
	input  logic                         arst_n,
	// Per-client request
	input  mem_cfg_pkg::addr_t           arb_addr [mem_cfg_pkg::IN],
	input  mem_cfg_pkg::word_t           arb_data [mem_cfg_pkg::IN],
	input  logic                         arb_wr [mem_cfg_pkg::IN],
	input  logic [mem_cfg_pkg::IN - 1:0] arb_req,
	output logic [mem_cfg_pkg::IN - 1:0] arb_ack,
	// Shared read return
	output mem_cfg_pkg::word_t           arb_data_out,
	output logic [mem_cfg_pkg::IN - 1:0] arb_valid
);

	// Ports to arbiter
	logic [mem_cfg_pkg::IN - 1:0] pend;
	mem_cmd_pkg::mem_op_e pend_op [mem_cfg_pkg::IN];
	mem_cfg_pkg::addr_t pend_addr [mem_cfg_pkg::IN];
	mem_cfg_pkg::word_t pend_data [mem_cfg_pkg::IN];
	logic [mem_cfg_pkg::IN - 1:0] grant;

	// Arbiter to memory
	logic cmd_valid;
	mem_cmd_pkg::mem_op_e cmd_op;
	mem_cfg_pkg::addr_t cmd_addr;
	mem_cfg_pkg::word_t cmd_data;
	mem_cfg_pkg::client_t cmd_owner;
	logic busy;

	// Memory to ports
	logic rsp_valid;
	mem_cfg_pkg::client_t rsp_owner;

	for (genvar i = 0; i < mem_cfg_pkg::IN; i++) begin : g_port
		localparam mem_cfg_pkg::client_t ID = mem_cfg_pkg::client_t'(i);

		client_port #(.ID(ID)) port0 (
			.clk10M(clk10M), .arst_n(arst_n),
			.req(arb_req[i]), .addr(arb_addr[i]), .data(arb_data[i]), .wr(arb_wr[i]),
			.grant(grant[i]), .rsp_valid(rsp_valid), .rsp_owner(rsp_owner),
			.ack(arb_ack[i]), .valid(arb_valid[i]),
			.pend(pend[i]), .pend_op(pend_op[i]),
			.pend_addr(pend_addr[i]), .pend_data(pend_data[i])
		);
	end

	rr_arbiter arb0 (
		.clk10M(clk10M), .arst_n(arst_n),
		.pend(pend), .pend_op(pend_op), .pend_addr(pend_addr), .pend_data(pend_data),
		.busy(busy), .grant(grant),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
		.cmd_data(cmd_data), .cmd_owner(cmd_owner)
	);

	burst_ram ram0 (
		.clk10M(clk10M), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
		.cmd_data(cmd_data), .cmd_owner(cmd_owner),
		.busy(busy), .rsp_valid(rsp_valid), .rsp_owner(rsp_owner),
		.rsp_data(arb_data_out)
	);

endmodule

/* tb/mem_ref_model.svh */
// Model state lives in the including module; contents are unknown until the fill test writes them
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

	// Reference copy of the burst memory
	mem_cfg_pkg::word_t ref_mem [mem_cfg_pkg::DEPTH];

	// Per client: words still to come back, and the cycle each burst should start
	mem_cfg_pkg::word_t exp_q [mem_cfg_pkg::IN][$];
	int due_q [mem_cfg_pkg::IN][$];
	int beat_cnt [mem_cfg_pkg::IN];

	// Client of the most recent ack
	mem_cfg_pkg::client_t last_grant;

	task automatic clear_model();
		for (int c = 0; c < mem_cfg_pkg::IN; c++) begin
			exp_q[c].delete();
			due_q[c].delete();
			beat_cnt[c] = 0;
		end
		// Search after reset starts at client 0
		last_grant = mem_cfg_pkg::client_t'(mem_cfg_pkg::IN - 1);
	endtask

	// Acks arrive in command completion order, so the model follows them directly
	task automatic record_ack(input int c, input logic wr, input mem_cfg_pkg::addr_t a,
		input mem_cfg_pkg::word_t d, input int cyc_now);
		mem_cfg_pkg::addr_t wa;
		if (wr) begin
			ref_mem[a] = d;
		end else begin
			for (int k = 0; k < mem_cfg_pkg::BURST; k++) begin
				// Wraps at the top of the 256-word array
				wa = mem_cfg_pkg::addr_t'((int'(a) + k) % mem_cfg_pkg::DEPTH);
				exp_q[c].push_back(ref_mem[wa]);
			end
			// First word two cycles after the ack
			due_q[c].push_back(cyc_now + 2);
		end
		last_grant = mem_cfg_pkg::client_t'(c);
	endtask

	// Next client in rotation when every client is pending
	function automatic mem_cfg_pkg::client_t next_grant(input mem_cfg_pkg::client_t last);
		return mem_cfg_pkg::client_t'((int'(last) + 1) % mem_cfg_pkg::IN);
	endfunction

	function automatic bit queues_empty();
		bit idle;
		idle = 1'b1;
		for (int c = 0; c < mem_cfg_pkg::IN; c++) begin
			if (exp_q[c].size() != 0)
				idle = 1'b0;
		end
		return idle;
	endfunction

`endif

/* tb/tb_mem_shared.sv */
// Self-checking testbench for mem_shared; reads come only after the fill test writes every word
`timescale 1ns/1ps

module tb_mem_shared;

	localparam int N_RR = 8;
	localparam int N_MIX = 24;
	// Fill writes and reads, wrap read, round robin, mixed traffic, write then read
	localparam int TOTAL_OPS = mem_cfg_pkg::DEPTH + mem_cfg_pkg::DEPTH / mem_cfg_pkg::BURST + 1
		+ mem_cfg_pkg::IN * N_RR + mem_cfg_pkg::IN * N_MIX + 2;
	localparam int CYCLE_LIMIT = TOTAL_OPS * (mem_cfg_pkg::BURST + 4) * mem_cfg_pkg::IN * 2;

	logic clk10M;
	logic arst_n;
	mem_cfg_pkg::addr_t arb_addr [mem_cfg_pkg::IN];
	mem_cfg_pkg::word_t arb_data [mem_cfg_pkg::IN];
	logic arb_wr [mem_cfg_pkg::IN];
	logic [mem_cfg_pkg::IN - 1:0] arb_req;
	logic [mem_cfg_pkg::IN - 1:0] arb_ack;
	mem_cfg_pkg::word_t arb_data_out;
	logic [mem_cfg_pkg::IN - 1:0] arb_valid;

	int cyc;
	int errors;
	int test_errors;
	int tests_passed;
	int tests_failed;
	bit rr_check;
	mem_cfg_pkg::word_t first_word [mem_cfg_pkg::IN];
	mem_cfg_pkg::addr_t rw_addr;
	mem_cfg_pkg::word_t rw_data;

	`include "mem_ref_model.svh"

	mem_shared dut0 (
		.clk10M(clk10M), .arst_n(arst_n),
		.arb_addr(arb_addr), .arb_data(arb_data), .arb_wr(arb_wr),
		.arb_req(arb_req), .arb_ack(arb_ack),
		.arb_data_out(arb_data_out), .arb_valid(arb_valid)
	);

	initial begin
		clk10M = 1'b0;
		forever #50 clk10M = ~clk10M;
	end

	task automatic compare_word(input mem_cfg_pkg::word_t got, input mem_cfg_pkg::word_t exp,
		input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic compare_client(input mem_cfg_pkg::client_t got,
		input mem_cfg_pkg::client_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got client %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// One returned word for client c
	task automatic check_valid(input int c);
		mem_cfg_pkg::word_t exp;
		int due;
		if (exp_q[c].size() == 0) begin
			$display("Client %0d got a read word at %0t with no read outstanding", c, $time);
			errors++;
		end else begin
			if (beat_cnt[c] == 0) begin
				due = due_q[c].pop_front();
				first_word[c] = arb_data_out;
				if (due != cyc) begin
					$display("Mismatch at %0t: client %0d first word at cycle %0d, expected %0d",
						$time, c, cyc, due);
					errors++;
				end
			end
			exp = exp_q[c].pop_front();
			compare_word(arb_data_out, exp, $sformatf("client %0d read word", c));
			beat_cnt[c] = (beat_cnt[c] + 1) % mem_cfg_pkg::BURST;
		end
	endtask

	// Samples DUT outputs on the rising edge, before this edge's updates land
	always @(posedge clk10M) begin
		if (arst_n) begin
			for (int c = 0; c < mem_cfg_pkg::IN; c++) begin
				if (arb_ack[c]) begin
					if (rr_check)
						compare_client(mem_cfg_pkg::client_t'(c), next_grant(last_grant),
							"ack order");
					record_ack(c, arb_wr[c], arb_addr[c], arb_data[c], cyc);
				end
				if (arb_valid[c])
					check_valid(c);
			end
		end
		cyc++;
	end

	// Called on a rising edge; returns on the edge that sees the ack, req still high
	task automatic issue(input int c, input logic wr, input mem_cfg_pkg::addr_t a,
		input mem_cfg_pkg::word_t d);
		arb_req[c] <= 1'b1;
		arb_wr[c] <= wr;
		arb_addr[c] <= a;
		arb_data[c] <= d;
		do
			@(posedge clk10M);
		while (!arb_ack[c]);
	endtask

	task automatic release_req(input int c);
		arb_req[c] <= 1'b0;
	endtask

	task automatic run_client(input int c, input int n, input bit gaps);
		int idle;
		logic wr;
		for (int k = 0; k < n; k++) begin
			idle = gaps ? $urandom_range(0, 3) : 0;
			if (idle > 0) begin
				arb_req[c] <= 1'b0;
				repeat (idle) @(posedge clk10M);
			end
			wr = $urandom_range(0, 1);
			issue(c, wr, mem_cfg_pkg::addr_t'($urandom), mem_cfg_pkg::word_t'($urandom));
		end
		release_req(c);
	endtask

	// Queues are checked at the falling edge, after the monitor has run
	task automatic wait_drained();
		do
			@(negedge clk10M);
		while (!queues_empty());
		repeat (3) @(posedge clk10M);
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - test_errors);
		end
	endtask

	initial begin
		wait (cyc >= CYCLE_LIMIT);
		$display("Run stalled: tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(54945));
		arst_n = 1'b0;
		arb_req = '0;
		for (int c = 0; c < mem_cfg_pkg::IN; c++) begin
			arb_addr[c] = '0;
			arb_data[c] = '0;
			arb_wr[c] = 1'b0;
		end
		cyc = 0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		rr_check = 1'b0;
		clear_model();
		repeat (2) @(posedge clk10M);
		arst_n <= 1'b1;

		// Quiet outputs with no request
		start_test();
		repeat (4) begin
			@(posedge clk10M);
			if (arb_ack !== '0 || arb_valid !== '0) begin
				$display("Ack or valid went high at %0t after reset with no request", $time);
				errors++;
			end
		end
		end_test("reset");

		start_test();
		@(posedge clk10M);
		for (int a = 0; a < mem_cfg_pkg::DEPTH; a++)
			issue(0, 1'b1, mem_cfg_pkg::addr_t'(a), mem_cfg_pkg::word_t'($urandom));
		for (int a = 0; a < mem_cfg_pkg::DEPTH; a += mem_cfg_pkg::BURST)
			issue(0, 1'b0, mem_cfg_pkg::addr_t'(a), '0);
		release_req(0);
		wait_drained();
		end_test("fill and read back");

		// Burst runs past address 255
		start_test();
		@(posedge clk10M);
		issue(2, 1'b0, mem_cfg_pkg::addr_t'(252), '0);
		release_req(2);
		wait_drained();
		end_test("wrapping burst");

		start_test();
		rr_check = 1'b1;
		@(posedge clk10M);
		fork
			run_client(0, N_RR, 1'b0);
			run_client(1, N_RR, 1'b0);
			run_client(2, N_RR, 1'b0);
			run_client(3, N_RR, 1'b0);
		join
		wait_drained();
		rr_check = 1'b0;
		end_test("round robin");

		start_test();
		@(posedge clk10M);
		fork
			run_client(0, N_MIX, 1'b1);
			run_client(1, N_MIX, 1'b1);
			run_client(2, N_MIX, 1'b1);
			run_client(3, N_MIX, 1'b1);
		join
		wait_drained();
		end_test("tagged return");

		// New data must differ from what the address held
		start_test();
		rw_addr = mem_cfg_pkg::addr_t'($urandom);
		rw_data = ~ref_mem[rw_addr];
		@(posedge clk10M);
		issue(1, 1'b1, rw_addr, rw_data);
		release_req(1);
		issue(3, 1'b0, rw_addr, '0);
		release_req(3);
		wait_drained();
		compare_word(first_word[3], rw_data, "read after write");
		end_test("write then read");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* sim.f */
+incdir+tb
rtl/mem_cfg_pkg.sv
rtl/mem_cmd_pkg.sv
rtl/client_port.sv
rtl/rr_arbiter.sv
rtl/burst_ram.sv
rtl/mem_shared.sv
tb/tb_mem_shared.sv

/* Bender.yml */
package:
  name: mem_shared

# Packages first, then the modules that use them
sources:
  - files:
      - rtl/mem_cfg_pkg.sv
      - rtl/mem_cmd_pkg.sv
      - rtl/client_port.sv
      - rtl/rr_arbiter.sv
      - rtl/burst_ram.sv
      - rtl/mem_shared.sv

  # Testbench and its reference model header
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mem_shared.sv
